/* harness_pkg.sv */
`default_nettype none

package harness_pkg;

  // ----------------------------------------------------------------------
  // debug module interface
  // ----------------------------------------------------------------------
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2
  } dmi_op_e;

  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dmi_op_e                 op;
    logic [DmiDataWidth-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [DmiDataWidth-1:0] data;
    logic [1:0]              resp;
  } dmi_resp_t;

  // simulation exit code width
  localparam int unsigned ExitWidth = 32;

  // core debug request held off this long after reset
  localparam int unsigned DmiDelCycles = 500;

  // ----------------------------------------------------------------------
  // interrupts, privileged spec bit positions
  // ----------------------------------------------------------------------
  localparam int unsigned XLen    = 64;
  localparam int unsigned IrqMsip = 3;
  localparam int unsigned IrqMtip = 7;
  localparam int unsigned IrqSeip = 9;
  localparam int unsigned IrqMeip = 11;

  // ----------------------------------------------------------------------
  // SoC address map
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth = 64;
  localparam int unsigned NumPorts  = 10;

  typedef enum logic [3:0] {
    PORT_DEBUG    = 4'd0,
    PORT_ROM      = 4'd1,
    PORT_CLINT    = 4'd2,
    PORT_PLIC     = 4'd3,
    PORT_UART     = 4'd4,
    PORT_TIMER    = 4'd5,
    PORT_SPI      = 4'd6,
    PORT_ETHERNET = 4'd7,
    PORT_GPIO     = 4'd8,
    PORT_DRAM     = 4'd9
  } port_idx_e;

  localparam logic [AddrWidth-1:0] DebugBase      = 64'h0000_0000;
  localparam logic [AddrWidth-1:0] DebugLength    = 64'h0000_1000;
  localparam logic [AddrWidth-1:0] RomBase        = 64'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength      = 64'h0001_0000;
  localparam logic [AddrWidth-1:0] ClintBase      = 64'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength    = 64'h000C_0000;
  localparam logic [AddrWidth-1:0] PlicBase       = 64'h0C00_0000;
  localparam logic [AddrWidth-1:0] PlicLength     = 64'h0400_0000;
  localparam logic [AddrWidth-1:0] UartBase       = 64'h1000_0000;
  localparam logic [AddrWidth-1:0] UartLength     = 64'h0000_1000;
  localparam logic [AddrWidth-1:0] TimerBase      = 64'h1800_0000;
  localparam logic [AddrWidth-1:0] TimerLength    = 64'h0000_1000;
  localparam logic [AddrWidth-1:0] SpiBase        = 64'h2000_0000;
  localparam logic [AddrWidth-1:0] SpiLength      = 64'h0080_0000;
  localparam logic [AddrWidth-1:0] EthernetBase   = 64'h3000_0000;
  localparam logic [AddrWidth-1:0] EthernetLength = 64'h0001_0000;
  localparam logic [AddrWidth-1:0] GpioBase       = 64'h4000_0000;
  localparam logic [AddrWidth-1:0] GpioLength     = 64'h0000_1000;
  localparam logic [AddrWidth-1:0] DramBase       = 64'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength     = 64'h4000_0000;

  // end_addr is exclusive
  typedef struct packed {
    port_idx_e             idx;
    logic [AddrWidth-1:0]  start_addr;
    logic [AddrWidth-1:0]  end_addr;
  } addr_rule_t;

  localparam addr_rule_t AddrMap [NumPorts] = '{
    '{idx: PORT_DEBUG,    start_addr: DebugBase,    end_addr: DebugBase + DebugLength},
    '{idx: PORT_ROM,      start_addr: RomBase,      end_addr: RomBase + RomLength},
    '{idx: PORT_CLINT,    start_addr: ClintBase,    end_addr: ClintBase + ClintLength},
    '{idx: PORT_PLIC,     start_addr: PlicBase,     end_addr: PlicBase + PlicLength},
    '{idx: PORT_UART,     start_addr: UartBase,     end_addr: UartBase + UartLength},
    '{idx: PORT_TIMER,    start_addr: TimerBase,    end_addr: TimerBase + TimerLength},
    '{idx: PORT_SPI,      start_addr: SpiBase,      end_addr: SpiBase + SpiLength},
    '{idx: PORT_ETHERNET, start_addr: EthernetBase, end_addr: EthernetBase + EthernetLength},
    '{idx: PORT_GPIO,     start_addr: GpioBase,     end_addr: GpioBase + GpioLength},
    '{idx: PORT_DRAM,     start_addr: DramBase,     end_addr: DramBase + DramLength}
  };

  // AXI style response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    port_idx_e port;
    resp_e     resp;
  } decode_t;

endpackage

`default_nettype wire

/* dmi_select.sv */
`timescale 1ns/1ps
`default_nettype none

module dmi_select (
  // source selection, 1 picks the JTAG bridge
  input  logic                             sel_jtag_i,

  // JTAG bridge side
  input  harness_pkg::dmi_req_t            jtag_req_i,
  input  logic                             jtag_req_valid_i,
  input  logic                             jtag_resp_ready_i,
  output logic                             jtag_resp_valid_o,
  input  logic [harness_pkg::ExitWidth-1:0] jtag_exit_i,

  // simulated DTM side
  input  harness_pkg::dmi_req_t            dtm_req_i,
  input  logic                             dtm_req_valid_i,
  input  logic                             dtm_resp_ready_i,
  output logic                             dtm_resp_valid_o,
  input  logic [harness_pkg::ExitWidth-1:0] dtm_exit_i,

  // debug module side
  output harness_pkg::dmi_req_t            dm_req_o,
  output logic                             dm_req_valid_o,
  output logic                             dm_resp_ready_o,
  input  logic                             dm_resp_valid_i,

  output logic [harness_pkg::ExitWidth-1:0] exit_o
);

  // ----------------------------------------------------------------------
  // request channel and response ready from the chosen source
  // ----------------------------------------------------------------------
  always_comb begin
    if (sel_jtag_i) begin
      dm_req_o        = jtag_req_i;
      dm_req_valid_o  = jtag_req_valid_i;
      dm_resp_ready_o = jtag_resp_ready_i;
      exit_o          = jtag_exit_i;
    end else begin
      dm_req_o        = dtm_req_i;
      dm_req_valid_o  = dtm_req_valid_i;
      dm_resp_ready_o = dtm_resp_ready_i;
      exit_o          = dtm_exit_i;
    end
  end

  // ----------------------------------------------------------------------
  // response valid steering
  // ----------------------------------------------------------------------
  // unselected source never sees a response
  always_comb begin
    jtag_resp_valid_o = 1'b0;
    dtm_resp_valid_o  = 1'b0;
    if (sel_jtag_i) begin
      jtag_resp_valid_o = dm_resp_valid_i;
    end else begin
      dtm_resp_valid_o  = dm_resp_valid_i;
    end
  end

endmodule

`default_nettype wire

/* debug_req_gate.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dm_debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  // wide enough to hold the full delay value
  logic [$clog2(harness_pkg::DmiDelCycles+1)-1:0] del_cnt_d;
  logic [$clog2(harness_pkg::DmiDelCycles+1)-1:0] del_cnt_q;
  logic                                           del_done;

  // gives the core time to run its boot code before
  // the debug module may halt it
  assign del_done = (del_cnt_q == '0);

  // count down, then stay at zero
  always_comb begin
    del_cnt_d = del_cnt_q;
    if (!del_done) begin
      del_cnt_d = del_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= harness_pkg::DmiDelCycles[$bits(del_cnt_q)-1:0];
    end else begin
      del_cnt_q <= del_cnt_d;
    end
  end

  assign debug_req_o = del_done & debug_enable_i & dm_debug_req_i;

endmodule

`default_nettype wire

/* addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             addr_valid_i,
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  output logic                             decode_valid_o,
  output harness_pkg::decode_t             decode_o
);

  logic [harness_pkg::NumPorts-1:0] rule_hit;
  harness_pkg::decode_t             decode_d;
  harness_pkg::decode_t             decode_q;
  logic                             valid_q;

  // ----------------------------------------------------------------------
  // range compare per region
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < harness_pkg::NumPorts; i++) begin : gen_rule
    assign rule_hit[i] = (addr_i >= harness_pkg::AddrMap[i].start_addr) &&
                         (addr_i <  harness_pkg::AddrMap[i].end_addr);
  end

  // ----------------------------------------------------------------------
  // port and response code
  // ----------------------------------------------------------------------
  // regions do not overlap, so at most one bit of rule_hit is set
  always_comb begin
    decode_d.port = harness_pkg::PORT_DEBUG;
    decode_d.resp = harness_pkg::RESP_DECERR;
    for (int unsigned i = 0; i < harness_pkg::NumPorts; i++) begin
      if (rule_hit[i]) begin
        decode_d.port = harness_pkg::AddrMap[i].idx;
        // GPIO hole, nothing behind it
        if (harness_pkg::AddrMap[i].idx == harness_pkg::PORT_GPIO) begin
          decode_d.resp = harness_pkg::RESP_SLVERR;
        end else begin
          decode_d.resp = harness_pkg::RESP_OKAY;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= addr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (addr_valid_i) begin
      decode_q <= decode_d;
    end
  end

  assign decode_valid_o = valid_q;
  assign decode_o       = decode_q;

endmodule

`default_nettype wire

/* harness_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module harness_glue (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // DMI source selection
  input  logic                              dmi_sel_jtag_i,

  // JTAG bridge
  input  harness_pkg::dmi_req_t             jtag_req_i,
  input  logic                              jtag_req_valid_i,
  input  logic                              jtag_resp_ready_i,
  output logic                              jtag_resp_valid_o,
  input  logic [harness_pkg::ExitWidth-1:0] jtag_exit_i,

  // simulated DTM
  input  harness_pkg::dmi_req_t             dtm_req_i,
  input  logic                              dtm_req_valid_i,
  input  logic                              dtm_resp_ready_i,
  output logic                              dtm_resp_valid_o,
  input  logic [harness_pkg::ExitWidth-1:0] dtm_exit_i,

  // debug module DMI port
  output harness_pkg::dmi_req_t             dm_req_o,
  output logic                              dm_req_valid_o,
  output logic                              dm_resp_ready_o,
  input  logic                              dm_resp_valid_i,
  output logic [harness_pkg::ExitWidth-1:0] exit_o,

  // core debug request
  input  logic                              dm_debug_req_i,
  input  logic                              debug_enable_i,
  output logic                              debug_req_o,

  // address decode
  input  logic                              addr_valid_i,
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  output logic                              decode_valid_o,
  output harness_pkg::decode_t              decode_o,

  // interrupts, irq_i[0] meip and irq_i[1] seip
  input  logic [1:0]                        irq_i,
  input  logic                              timer_irq_i,
  input  logic                              ipi_i,
  output logic [harness_pkg::XLen-1:0]      clint_irq_o
);

  // ----------------------------------------------------------------------
  // DMI source mux
  // ----------------------------------------------------------------------
  dmi_select u_dmi_select (
    .sel_jtag_i        ( dmi_sel_jtag_i    ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_exit_i       ( jtag_exit_i       ),
    .dtm_req_i         ( dtm_req_i         ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_exit_i        ( dtm_exit_i        ),
    .dm_req_o          ( dm_req_o          ),
    .dm_req_valid_o    ( dm_req_valid_o    ),
    .dm_resp_ready_o   ( dm_resp_ready_o   ),
    .dm_resp_valid_i   ( dm_resp_valid_i   ),
    .exit_o            ( exit_o            )
  );

  // ----------------------------------------------------------------------
  // debug request gating and address decode
  // ----------------------------------------------------------------------
  debug_req_gate u_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .dm_debug_req_i ( dm_debug_req_i ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

  addr_decode u_addr_decode (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .addr_valid_i   ( addr_valid_i   ),
    .addr_i         ( addr_i         ),
    .decode_valid_o ( decode_valid_o ),
    .decode_o       ( decode_o       )
  );

  // ----------------------------------------------------------------------
  // CLINT interrupt vector
  // ----------------------------------------------------------------------
  // reserved and platform bits stay zero
  always_comb begin
    clint_irq_o                       = '0;
    clint_irq_o[harness_pkg::IrqMsip] = ipi_i;
    clint_irq_o[harness_pkg::IrqMtip] = timer_irq_i;
    clint_irq_o[harness_pkg::IrqSeip] = irq_i[1];
    clint_irq_o[harness_pkg::IrqMeip] = irq_i[0];
  end

endmodule

`default_nettype wire

/* tb_harness_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_harness_glue;

  localparam int unsigned DelayMargin = 20;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              dmi_sel_jtag_i;
  harness_pkg::dmi_req_t             jtag_req_i;
  logic                              jtag_req_valid_i;
  logic                              jtag_resp_ready_i;
  logic                              jtag_resp_valid_o;
  logic [harness_pkg::ExitWidth-1:0] jtag_exit_i;
  harness_pkg::dmi_req_t             dtm_req_i;
  logic                              dtm_req_valid_i;
  logic                              dtm_resp_ready_i;
  logic                              dtm_resp_valid_o;
  logic [harness_pkg::ExitWidth-1:0] dtm_exit_i;
  harness_pkg::dmi_req_t             dm_req_o;
  logic                              dm_req_valid_o;
  logic                              dm_resp_ready_o;
  logic                              dm_resp_valid_i;
  logic [harness_pkg::ExitWidth-1:0] exit_o;
  logic                              dm_debug_req_i;
  logic                              debug_enable_i;
  logic                              debug_req_o;
  logic                              addr_valid_i;
  logic [harness_pkg::AddrWidth-1:0] addr_i;
  logic                              decode_valid_o;
  harness_pkg::decode_t              decode_o;
  logic [1:0]                        irq_i;
  logic                              timer_irq_i;
  logic                              ipi_i;
  logic [harness_pkg::XLen-1:0]      clint_irq_o;

  integer               seed;
  int unsigned          errors;
  int unsigned          checks;
  int unsigned          rise_count;
  int unsigned          addr_sent;
  int unsigned          decodes_seen;
  logic                 exp_valid_q;
  harness_pkg::decode_t exp_dec_q;

  harness_glue uut (.*);

  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic logic [63:0] region_base(input int unsigned idx);
    case (idx)
      0: return harness_pkg::DebugBase;
      1: return harness_pkg::RomBase;
      2: return harness_pkg::ClintBase;
      3: return harness_pkg::PlicBase;
      4: return harness_pkg::UartBase;
      5: return harness_pkg::TimerBase;
      6: return harness_pkg::SpiBase;
      7: return harness_pkg::EthernetBase;
      8: return harness_pkg::GpioBase;
      default: return harness_pkg::DramBase;
    endcase
  endfunction

  function automatic logic [63:0] region_len(input int unsigned idx);
    case (idx)
      0: return harness_pkg::DebugLength;
      1: return harness_pkg::RomLength;
      2: return harness_pkg::ClintLength;
      3: return harness_pkg::PlicLength;
      4: return harness_pkg::UartLength;
      5: return harness_pkg::TimerLength;
      6: return harness_pkg::SpiLength;
      7: return harness_pkg::EthernetLength;
      8: return harness_pkg::GpioLength;
      default: return harness_pkg::DramLength;
    endcase
  endfunction

  // region index equals the port number
  function automatic harness_pkg::decode_t ref_decode(input logic [63:0] addr);
    harness_pkg::decode_t d;
    logic [63:0]          base;
    d.port = harness_pkg::PORT_DEBUG;
    d.resp = harness_pkg::RESP_DECERR;
    for (int unsigned i = 0; i < harness_pkg::NumPorts; i++) begin
      base = region_base(i);
      if (addr >= base && (addr - base) < region_len(i)) begin
        d.port = harness_pkg::port_idx_e'(i[3:0]);
        if (d.port == harness_pkg::PORT_GPIO) begin
          d.resp = harness_pkg::RESP_SLVERR;
        end else begin
          d.resp = harness_pkg::RESP_OKAY;
        end
      end
    end
    return d;
  endfunction

  function automatic logic [63:0] ref_irq(input logic [1:0] irq, input logic timer,
                                          input logic ipi);
    logic [63:0] v;
    v                       = '0;
    v[harness_pkg::IrqMsip] = ipi;
    v[harness_pkg::IrqMtip] = timer;
    v[harness_pkg::IrqSeip] = irq[1];
    v[harness_pkg::IrqMeip] = irq[0];
    return v;
  endfunction

  function automatic logic ref_debug_req(input int unsigned edges, input logic en,
                                         input logic req);
    return (edges >= harness_pkg::DmiDelCycles) && en && req;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // comparing processes
  // ----------------------------------------------------------------------
  // rising edges seen since reset release
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rise_count <= 0;
    end else if (rise_count < harness_pkg::DmiDelCycles + DelayMargin) begin
      rise_count <= rise_count + 1;
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk_i) begin : compare_outputs
    harness_pkg::dmi_req_t             exp_req;
    logic                              exp_valid;
    logic                              exp_ready;
    logic [harness_pkg::ExitWidth-1:0] exp_exit;
    exp_req   = dmi_sel_jtag_i ? jtag_req_i : dtm_req_i;
    exp_valid = dmi_sel_jtag_i ? jtag_req_valid_i : dtm_req_valid_i;
    exp_ready = dmi_sel_jtag_i ? jtag_resp_ready_i : dtm_resp_ready_i;
    exp_exit  = dmi_sel_jtag_i ? jtag_exit_i : dtm_exit_i;
    check_equal("dm_req_o", 64'(dm_req_o), 64'(exp_req));
    check_equal("dm_req_valid_o", 64'(dm_req_valid_o), 64'(exp_valid));
    check_equal("dm_resp_ready_o", 64'(dm_resp_ready_o), 64'(exp_ready));
    check_equal("exit_o", 64'(exit_o), 64'(exp_exit));
    check_equal("jtag_resp_valid_o", 64'(jtag_resp_valid_o),
                64'(dmi_sel_jtag_i & dm_resp_valid_i));
    check_equal("dtm_resp_valid_o", 64'(dtm_resp_valid_o),
                64'(!dmi_sel_jtag_i & dm_resp_valid_i));
    check_equal("debug_req_o", 64'(debug_req_o),
                64'(ref_debug_req(rise_count, debug_enable_i, dm_debug_req_i)));
    // decode of the address seen one cycle earlier
    check_equal("decode_valid_o", 64'(decode_valid_o), 64'(exp_valid_q));
    if (decode_valid_o) begin
      decodes_seen++;
    end
    if (exp_valid_q) begin
      check_equal("decode_o", 64'(decode_o), 64'(exp_dec_q));
    end
    exp_valid_q = rst_ni & addr_valid_i;
    exp_dec_q   = ref_decode(addr_i);
    check_equal("clint_irq_o", clint_irq_o, ref_irq(irq_i, timer_irq_i, ipi_i));
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  task automatic send_addr(input logic [63:0] addr);
    @(posedge clk_i);
    #1;
    addr_valid_i = 1'b1;
    addr_i       = addr;
    addr_sent++;
  endtask

  initial begin : stimulus
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic        seen;
    seed              = 32'h36033a15;
    errors            = 0;
    checks            = 0;
    addr_sent         = 0;
    decodes_seen      = 0;
    exp_valid_q       = 1'b0;
    exp_dec_q         = '0;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    dmi_sel_jtag_i    = 1'b0;
    jtag_req_i        = '0;
    jtag_req_valid_i  = 1'b0;
    jtag_resp_ready_i = 1'b0;
    jtag_exit_i       = '0;
    dtm_req_i         = '0;
    dtm_req_valid_i   = 1'b0;
    dtm_resp_ready_i  = 1'b0;
    dtm_exit_i        = '0;
    dm_resp_valid_i   = 1'b0;
    dm_debug_req_i    = 1'b1;
    debug_enable_i    = 1'b1;
    addr_valid_i      = 1'b0;
    addr_i            = '0;
    irq_i             = '0;
    timer_irq_i       = 1'b0;
    ipi_i             = 1'b0;

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // debug request held off after reset
    seen = 1'b0;
    for (int unsigned cyc = 0; cyc < harness_pkg::DmiDelCycles + DelayMargin && !seen;
         cyc++) begin
      @(negedge clk_i);
      seen = debug_req_o;
    end
    if (!seen) begin
      errors++;
      $display("timeout: debug_req_o did not rise after reset release");
    end else begin
      check_equal("debug_req_o delay", 64'(rise_count), 64'(harness_pkg::DmiDelCycles));
    end

    // enable gating with the enable low first
    for (int k = 0; k < 180; k++) begin
      @(posedge clk_i);
      #1;
      r1             = $random(seed);
      dm_debug_req_i = r1[0];
      debug_enable_i = (k < 60) ? 1'b0 : ((k < 120) ? 1'b1 : r1[1]);
    end

    // DMI source selection
    for (int k = 0; k < 300; k++) begin
      @(posedge clk_i);
      #1;
      r1                = $random(seed);
      r2                = $random(seed);
      r3                = $random(seed);
      dmi_sel_jtag_i    = r1[0];
      jtag_req_valid_i  = r1[1];
      jtag_resp_ready_i = r1[2];
      dtm_req_valid_i   = r1[3];
      dtm_resp_ready_i  = r1[4];
      dm_resp_valid_i   = r1[5];
      jtag_req_i.addr   = r1[14:8];
      jtag_req_i.op     = harness_pkg::dmi_op_e'(r1[17:16] % 2'd3);
      jtag_req_i.data   = r2;
      dtm_req_i.addr    = r1[26:20];
      dtm_req_i.op      = harness_pkg::dmi_op_e'(r1[29:28] % 2'd3);
      dtm_req_i.data    = r3;
      jtag_exit_i       = r2 ^ r3;
      dtm_exit_i        = $random(seed);
    end

    // address decode at the region edges and then at random addresses
    for (int unsigned i = 0; i < harness_pkg::NumPorts; i++) begin
      send_addr(region_base(i));
      send_addr(region_base(i) + region_len(i) - 64'd1);
      send_addr(region_base(i) + region_len(i));
    end
    for (int k = 0; k < 200; k++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      case (r1[1:0])
        2'd0: send_addr({r1, r2});
        2'd1: send_addr({32'h0, r2});
        2'd2: send_addr(region_base(r1 % 10) + ({32'h0, r2} % region_len(r1 % 10)));
        default: send_addr({32'h0, r2[31:28], 16'h0, r2[11:0]});
      endcase
    end
    @(posedge clk_i);
    #1;
    addr_valid_i = 1'b0;

    // interrupt packing
    for (int k = 0; k < 100; k++) begin
      @(posedge clk_i);
      #1;
      r1          = $random(seed);
      irq_i       = r1[1:0];
      timer_irq_i = r1[2];
      ipi_i       = r1[3];
    end

    @(posedge clk_i);
    #1;
    check_equal("decode count", 64'(decodes_seen), 64'(addr_sent));

    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
harness_pkg.sv
dmi_select.sv
debug_req_gate.sv
addr_decode.sv
harness_glue.sv
tb_harness_glue.sv

/* Makefile */
# Verilator simulation of harness_glue

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, then check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_harness_glue -Mdir obj_dir -o sim_harness_glue
	./obj_dir/sim_harness_glue | tee sim.log
	@if grep -q "Simulation finished: PASS" sim.log; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
